/* build.f */
design/macc_pkg.sv
design/macc_cfg_regs.sv
design/vec_operand_mem.sv
design/sig_muladd.sv
design/result_credit_out.sv
design/macc_top.sv
testbench/macc_chk.sv
testbench/tb_macc.sv

/* run_sim.sh */
#!/bin/sh
# build and run the macc testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_macc \
   -f build.f -o tb_macc_sim || { echo "build failed"; exit 1; }
sim_out="$(./obj_dir/tb_macc_sim)"
echo "$sim_out"
echo "$sim_out" | grep -q "PASS: all tests" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* testbench/tb_macc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_macc;

   import macc_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int WATCHDOG_CYCLES = 6 * 200;   // six tests of at most 200 cycles.

   logic             clk;
   logic             rst;
   logic             cfg_we;
   cfg_addr_t        cfg_addr;
   logic [CFG_W-1:0] cfg_wdata;
   logic [CFG_W-1:0] cfg_rdata;
   logic             op_we;
   logic             op_sel;
   logic [3:0]       op_addr;
   logic [15:0]      op_wdata;
   logic             credit_in;
   logic             out_valid;
   logic [15:0]      out_data;

   logic [15:0] exp_q [$];        // results still owed by the output port.
   logic [15:0] exp_head = '0;
   int          exp_count = 0;
   int          sent_total = 0;
   bit          send_seen = 1'b0;
   int          errors = 0;
   int          errors_at_start = 0;
   int          failed_tests = 0;
   integer      seed = 21;
   int          a_val [16];
   int          b_val [16];

   macc_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .op_we     (op_we),
      .op_sel    (op_sel),
      .op_addr   (op_addr),
      .op_wdata  (op_wdata),
      .credit_in (credit_in),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   // output checks, sampled mid-cycle where the port is settled.
   a_out_expected: assert property (@(negedge clk) disable iff (rst)
      out_valid |-> exp_count != 0)
      else begin
         errors++;
         $display("output port sent a result while none was expected");
      end

   a_out_data: assert property (@(negedge clk) disable iff (rst)
      (out_valid && exp_count != 0) |-> out_data == exp_head)
      else begin
         errors++;
         $display("[FAIL] out_data: got 0x%h expected 0x%h", out_data, exp_head);
      end

   function automatic void refresh_head();
      exp_count = exp_q.size();
      exp_head  = (exp_count != 0) ? exp_q[0] : '0;
   endfunction

   always @(negedge clk) send_seen <= !rst && out_valid;   // transfer at the next rising edge.

   always @(posedge clk) begin
      if (send_seen) begin
         if (exp_q.size() != 0) begin
            void'(exp_q.pop_front());
         end
         sent_total++;
         refresh_head();
      end
   end

   // sum of products, negated for msub, cut to the port width.
   function automatic logic [15:0] expected_result(input int n, input macc_op_t op);
      int sum;
      sum = 0;
      for (int k = 0; k < n; k++) begin
         sum += a_val[k] * b_val[k];
      end
      if (op == OP_MSUB) begin
         sum = -sum;
      end
      return sum[15:0];
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic cfg_write(input cfg_addr_t addr, input logic [CFG_W-1:0] data);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      next_cycle();
      cfg_we = 1'b0;
   endtask

   task automatic check_reg(input cfg_addr_t addr, input logic [CFG_W-1:0] expected);
      cfg_addr = addr;
      @(negedge clk);
      assert (cfg_rdata == expected) else begin
         errors++;
         $display("[FAIL] cfg_rdata: got 0x%h expected 0x%h", cfg_rdata, expected);
      end
      next_cycle();
   endtask

   task automatic write_operand(input logic sel, input int addr, input int value);
      op_we    = 1'b1;
      op_sel   = sel;
      op_addr  = addr[3:0];
      op_wdata = value[15:0];
      next_cycle();
      op_we = 1'b0;
   endtask

   task automatic load_operands(input int n);
      logic [31:0] r;
      for (int k = 0; k < n; k++) begin
         r = $random(seed);
         a_val[k] = $signed(r[7:0]);    // signed 8-bit range.
         b_val[k] = $signed(r[15:8]);
         write_operand(1'b0, k, a_val[k]);
         write_operand(1'b1, k, b_val[k]);
      end
   endtask

   task automatic start_run(input int n, input macc_op_t op);
      cfg_write(REG_OPCODE, CFG_W'(op));
      cfg_write(REG_AMOUNT, CFG_W'(n));
      exp_q.push_back(expected_result(n, op));
      refresh_head();
      cfg_write(REG_START, '0);
   endtask

   task automatic wait_sent(input int target);
      int waited;
      waited = 0;
      while (sent_total < target && waited < 100) begin
         next_cycle();
         waited++;
      end
      assert (sent_total >= target) else begin
         errors++;
         $display("timed out waiting for result %0d on the output port", target);
      end
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      cfg_addr = REG_STATUS;
      @(negedge clk);
      while (cfg_rdata[0] && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      assert (!cfg_rdata[0]) else begin
         errors++;
         $display("busy stayed high, the run never finished");
      end
      next_cycle();
   endtask

   task automatic return_credit();
      credit_in = 1'b1;
      next_cycle();
      credit_in = 1'b0;
   endtask

   task automatic finish_test(input int num, input string name);
      if (errors == errors_at_start) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
      end
      errors_at_start = errors;
   endtask

   initial begin
      rst       = 1'b1;
      cfg_we    = 1'b0;
      cfg_addr  = REG_OPCODE;
      cfg_wdata = '0;
      op_we     = 1'b0;
      op_sel    = 1'b0;
      op_addr   = '0;
      op_wdata  = '0;
      credit_in = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      next_cycle();

      check_reg(REG_DELAY, CFG_W'(ALIGN_DELAY));
      cfg_write(REG_OPCODE, 32'h0000_0001);
      check_reg(REG_OPCODE, 32'h0000_0001);
      cfg_write(REG_AMOUNT, 32'h0000_a5c3);
      check_reg(REG_AMOUNT, 32'h0000_a5c3);
      cfg_write(REG_DELAY, 32'h0000_0007);
      check_reg(REG_DELAY, 32'h0000_0007);
      cfg_write(REG_DELAY, CFG_W'(ALIGN_DELAY));   // back to the aligned pipeline.
      load_operands(3);
      start_run(3, OP_MACC);
      check_reg(REG_STATUS, 32'h0000_0001);
      wait_sent(1);
      return_credit();
      finish_test(1, "register readback");

      load_operands(8);
      start_run(8, OP_MACC);
      wait_sent(2);
      return_credit();
      finish_test(2, "macc run");

      load_operands(5);
      start_run(5, OP_MSUB);
      wait_sent(3);
      return_credit();
      finish_test(3, "msub run");

      load_operands(1);
      start_run(1, OP_MACC);
      wait_sent(4);
      return_credit();
      finish_test(4, "single element");

      // both credits get used up, the third result has to wait.
      load_operands(4);
      start_run(4, OP_MACC);
      wait_sent(5);
      start_run(4, OP_MSUB);
      wait_sent(6);
      start_run(2, OP_MACC);
      wait_idle();
      repeat (4) next_cycle();
      assert (sent_total == 6 && !out_valid) else begin
         errors++;
         $display("third result left the port without a credit");
      end
      return_credit();
      wait_sent(7);
      return_credit();
      return_credit();
      finish_test(5, "credit back-pressure");

      load_operands(8);
      start_run(8, OP_MSUB);
      repeat (2) next_cycle();
      cfg_write(REG_AMOUNT, CFG_W'(3));   // a restart would sum only three.
      cfg_write(REG_START, '0);   // lands mid-run.
      wait_sent(8);
      return_credit();
      wait_idle();
      repeat (20) next_cycle();
      assert (exp_count == 0 && sent_total == 8) else begin
         errors++;
         $display("start written during a run changed the number of results");
      end
      finish_test(6, "start while busy");

      $display("tests run: 6, failed: %0d, errors: %0d", failed_tests, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/macc_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module macc_chk #(
   parameter int CREDITS = 2,
   parameter int CNT_W   = $clog2(CREDITS + 1)
) (
   input wire             clk,
   input wire             rst,
   input wire             out_valid,
   input wire             credit_in,
   input wire [CNT_W-1:0] credits
);

   logic [CNT_W:0] rx_credits;   // credits as the receiver sees them, one spare bit.

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rx_credits <= (CNT_W + 1)'(CREDITS);
      end else begin
         rx_credits <= rx_credits + (CNT_W + 1)'(credit_in) - (CNT_W + 1)'(out_valid);
      end
   end

   // a send always spends a credit the receiver handed out.
   a_send_needs_credit: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> rx_credits != '0)
      else $error("output valid with no credit left");

   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
      credits <= CNT_W'(CREDITS))   // returns never exceed what was sent.
      else $error("credit count above its limit");

   // the queue starts empty.
   a_quiet_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !out_valid)
      else $error("output valid in the first cycle after reset");

endmodule

bind result_credit_out macc_chk #(
   .CREDITS (CREDITS)
) chk_i (
   .clk       (clk),
   .rst       (rst),
   .out_valid (out_valid),
   .credit_in (credit_in),
   .credits   (credits)
);

`default_nettype wire

/* design/macc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module macc_top #(
   parameter int DATA_W    = 16,
   parameter int MEM_DEPTH = 16,
   parameter int CREDITS   = 2
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          cfg_we,
   input  wire macc_pkg::cfg_addr_t     cfg_addr,
   input  wire [macc_pkg::CFG_W-1:0]    cfg_wdata,
   output logic [macc_pkg::CFG_W-1:0]   cfg_rdata,
   input  wire                          op_we,
   input  wire                          op_sel,
   input  wire [$clog2(MEM_DEPTH)-1:0]  op_addr,
   input  wire [DATA_W-1:0]             op_wdata,
   input  wire                          credit_in,
   output logic                         out_valid,
   output logic [DATA_W-1:0]            out_data
);

   import macc_pkg::*;

   macc_op_t          opcode;
   logic [CFG_W-1:0]  amount;
   logic [CFG_W-1:0]  delay0;
   logic              run;
   logic              acc_clear;
   logic              rd_start;
   logic              done;
   logic [DATA_W-1:0] in0;
   logic [DATA_W-1:0] in1;
   logic [DATA_W-1:0] out0;

   macc_cfg_regs cfg_regs_i (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .done      (done),
      .opcode    (opcode),
      .amount    (amount),
      .delay0    (delay0),
      .run       (run),
      .acc_clear (acc_clear),
      .rd_start  (rd_start)
   );

   vec_operand_mem #(
      .DATA_W    (DATA_W),
      .MEM_DEPTH (MEM_DEPTH)
   ) operand_mem_i (
      .clk      (clk),
      .rst      (rst),
      .op_we    (op_we),
      .op_sel   (op_sel),
      .op_addr  (op_addr),
      .op_wdata (op_wdata),
      .rd_start (rd_start),
      .in0      (in0),
      .in1      (in1)
   );

   sig_muladd #(
      .DATA_W (DATA_W)
   ) muladd_i (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .acc_clear (acc_clear),
      .opcode    (opcode),
      .amount    (amount),
      .delay0    (delay0),
      .in0       (in0),
      .in1       (in1),
      .done      (done),
      .out0      (out0)
   );

   result_credit_out #(
      .DATA_W  (DATA_W),
      .CREDITS (CREDITS)
   ) credit_out_i (
      .clk       (clk),
      .rst       (rst),
      .done      (done),
      .out0      (out0),
      .credit_in (credit_in),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

endmodule

`default_nettype wire

/* design/result_credit_out.sv */
`timescale 1ns/1ps
`default_nettype none

module result_credit_out #(
   parameter int DATA_W  = 16,
   parameter int CREDITS = 2
) (
   input  wire                clk,
   input  wire                rst,
   input  wire                done,
   input  wire [DATA_W-1:0]   out0,
   input  wire                credit_in,
   output logic               out_valid,
   output logic [DATA_W-1:0]  out_data
);

   localparam int CNT_W = $clog2(CREDITS + 1);

   logic              done_q1;
   logic              done_q2;
   logic              capture;
   logic              push;
   logic [DATA_W-1:0] q_data [2];
   logic              wr_ptr;
   logic              rd_ptr;
   logic [1:0]        q_count;
   logic [CNT_W-1:0]  credits;   // credits held toward the receiver.

   // done is a level, so look for its rising edge one cycle late.
   // by then out0 carries the final sum.
   assign capture = done_q1 && !done_q2;
   assign push    = capture && (q_count != 2'd2);   // dropped when full.

   // the head goes out whenever a credit is left.
   assign out_valid = (q_count != 2'd0) && (credits != '0);
   assign out_data  = q_data[rd_ptr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_q1 <= 1'b0;
         done_q2 <= 1'b0;
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         q_count <= 2'd0;
         credits <= CNT_W'(CREDITS);
      end else begin
         done_q1 <= done;
         done_q2 <= done_q1;
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (out_valid) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, out_valid})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
         case ({out_valid, credit_in})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;   // send and return cancel.
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_data[wr_ptr] <= out0;
      end
   end

endmodule

`default_nettype wire

/* design/sig_muladd.sv */
`timescale 1ns/1ps
`default_nettype none

module sig_muladd #(
   parameter int DATA_W = 16
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          run,
   input  wire                          acc_clear,
   input  wire macc_pkg::macc_op_t      opcode,
   input  wire [macc_pkg::CFG_W-1:0]    amount,
   input  wire [macc_pkg::CFG_W-1:0]    delay0,
   input  wire [DATA_W-1:0]             in0,
   input  wire [DATA_W-1:0]             in1,
   output logic                         done,
   output logic [DATA_W-1:0]            out0
);

   import macc_pkg::*;

   logic [CFG_W-1:0]           delay_cnt;    // cycles before the accumulator opens.
   logic [CFG_W-1:0]           to_process;   // elements still to accumulate.
   logic                       active;
   logic                       acc_en;
   logic signed [DATA_W-1:0]   in0_reg;
   logic signed [DATA_W-1:0]   in1_reg;
   logic signed [2*DATA_W-1:0] prod_reg;
   logic signed [2*DATA_W-1:0] acc;
   logic signed [2*DATA_W-1:0] acc_out;

   assign acc_en = active && (delay_cnt == '0) && (to_process != '0);

   // control.
   // the extra count covers the operand and product registers.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done       <= 1'b0;
         active     <= 1'b0;
         delay_cnt  <= '0;
         to_process <= '0;
      end else if (run) begin
         done       <= 1'b0;
         active     <= 1'b1;
         delay_cnt  <= delay0 + 1'b1;
         to_process <= amount;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
      end else if (active) begin
         if (to_process != '0) begin
            to_process <= to_process - 1'b1;
         end
         if (to_process <= CFG_W'(1)) begin
            done   <= 1'b1;   // stays high until the next run.
            active <= 1'b0;
         end
      end
   end

   // operand and product pipeline.
   always_ff @(posedge clk) begin
      in0_reg  <= in0;
      in1_reg  <= in1;
      prod_reg <= in0_reg * in1_reg;   // signed, full width.
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc     <= '0;
         acc_out <= '0;
      end else begin
         if (acc_clear) begin
            acc <= '0;
         end else if (acc_en) begin
            if (opcode == OP_MACC) begin
               acc <= acc + prod_reg;
            end else begin
               acc <= acc - prod_reg;
            end
         end
         acc_out <= acc;
      end
   end

   assign out0 = acc_out[DATA_W-1:0];   // low half only.

endmodule

`default_nettype wire

/* design/vec_operand_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module vec_operand_mem #(
   parameter int DATA_W    = 16,
   parameter int MEM_DEPTH = 16
) (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          op_we,
   input  wire                          op_sel,
   input  wire [$clog2(MEM_DEPTH)-1:0]  op_addr,
   input  wire [DATA_W-1:0]             op_wdata,
   input  wire                          rd_start,
   output logic [DATA_W-1:0]            in0,
   output logic [DATA_W-1:0]            in1
);

   localparam int ADDR_W = $clog2(MEM_DEPTH);
   localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(MEM_DEPTH - 1);

   logic [DATA_W-1:0] mem_a [MEM_DEPTH];   // operand a, drives in0.
   logic [DATA_W-1:0] mem_b [MEM_DEPTH];   // operand b, drives in1.
   logic [ADDR_W-1:0] rd_addr;

   // host write port, op_sel picks the memory.
   always_ff @(posedge clk) begin
      if (op_we) begin
         if (op_sel) begin
            mem_b[op_addr] <= op_wdata;
         end else begin
            mem_a[op_addr] <= op_wdata;
         end
      end
   end

   // read address.
   // restarts at 0 on rd_start and stops at the last entry.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_addr <= '0;
      end else if (rd_start) begin
         rd_addr <= '0;
      end else if (rd_addr != LAST_ADDR) begin
         rd_addr <= rd_addr + 1'b1;
      end
   end

   // synchronous read, element k shows up one cycle after address k.
   always_ff @(posedge clk) begin
      in0 <= mem_a[rd_addr];
      in1 <= mem_b[rd_addr];
   end

endmodule

`default_nettype wire

/* design/macc_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module macc_cfg_regs (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          cfg_we,
   input  wire macc_pkg::cfg_addr_t     cfg_addr,
   input  wire [macc_pkg::CFG_W-1:0]    cfg_wdata,
   output logic [macc_pkg::CFG_W-1:0]   cfg_rdata,
   input  wire                          done,
   output macc_pkg::macc_op_t           opcode,
   output logic [macc_pkg::CFG_W-1:0]   amount,
   output logic [macc_pkg::CFG_W-1:0]   delay0,
   output logic                         run,
   output logic                         acc_clear,
   output logic                         rd_start
);

   import macc_pkg::*;

   logic busy;

   // a start while a run is in flight is dropped.
   assign run       = cfg_we && (cfg_addr == REG_START) && !busy;
   assign acc_clear = run;   // fresh accumulator for every run.
   assign rd_start  = run;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         opcode <= OP_MACC;
         amount <= '0;
         delay0 <= CFG_W'(ALIGN_DELAY);
      end else if (cfg_we) begin
         case (cfg_addr)
            REG_OPCODE: opcode <= macc_op_t'(cfg_wdata[0]);
            REG_AMOUNT: amount <= cfg_wdata;
            REG_DELAY:  delay0 <= cfg_wdata;
            default: ;   // start is handled above, status is read only.
         endcase
      end
   end

   // busy spans from the start pulse to the done of the muladd unit.
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (run) begin
         busy <= 1'b1;
      end else if (done) begin
         busy <= 1'b0;
      end
   end

   // readback.
   always_comb begin
      cfg_rdata = '0;
      case (cfg_addr)
         REG_OPCODE: cfg_rdata = CFG_W'(opcode);
         REG_AMOUNT: cfg_rdata = amount;
         REG_DELAY:  cfg_rdata = delay0;
         REG_STATUS: cfg_rdata[STATUS_BUSY_BIT] = busy;
         default:    cfg_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

/* design/macc_pkg.sv */
`default_nettype none

package macc_pkg;

   // width of the configuration bus and of the amount and delay registers.
   localparam int CFG_W = 32;

   // delay value that lines element 0 up with the first accumulate.
   localparam int ALIGN_DELAY = 2;

   // position of the busy flag in the status register.
   localparam int STATUS_BUSY_BIT = 0;

   // accumulate direction for the product.
   typedef enum logic [0:0] {
      OP_MACC = 1'b0,   // acc gets acc + a*b.
      OP_MSUB = 1'b1    // acc gets acc - a*b.
   } macc_op_t;

   // configuration register map.
   typedef enum logic [2:0] {
      REG_OPCODE = 3'd0,
      REG_AMOUNT = 3'd1,   // number of elements per run.
      REG_DELAY  = 3'd2,
      REG_START  = 3'd3,   // any write here launches a run.
      REG_STATUS = 3'd4    // read only.
   } cfg_addr_t;

endpackage

`default_nettype wire
